//--- common/cpu_pkg.sv
// ------------------------------
// Shared widths, opcodes and control types of the RV32I core
// Referenced by scoped name from every core module
// ------------------------------
`default_nettype none

package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [2:0]  funct3_t;    // Branch condition or access size

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

    // Decoded controls of the instruction in flight
    typedef struct packed {
        alu_op_e   alu_op;
        logic      use_pc_a;     // A operand is the PC
        logic      use_imm_b;    // B operand is the immediate
        logic      is_load;
        logic      is_store;
        logic      is_branch;
        logic      is_jal;
        logic      is_jalr;
        logic      is_ebreak;
        logic      reg_write;
        funct3_t   funct3;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
    } ctrl_t;

    // One bus request, instruction fetch or data access
    typedef struct packed {
        word_t   addr;
        word_t   wdata;      // Store data in the low lanes
        logic    read;
        logic    write;
        funct3_t size;
    } mem_req_t;

    // ------------------------------
    // Major opcodes
    // ------------------------------
    localparam logic [6:0] OP_LOAD   = 7'h03;
    localparam logic [6:0] OP_STORE  = 7'h23;
    localparam logic [6:0] OP_BRANCH = 7'h63;
    localparam logic [6:0] OP_JAL    = 7'h6F;
    localparam logic [6:0] OP_JALR   = 7'h67;
    localparam logic [6:0] OP_IMM    = 7'h13;
    localparam logic [6:0] OP_REG    = 7'h33;
    localparam logic [6:0] OP_LUI    = 7'h37;
    localparam logic [6:0] OP_AUIPC  = 7'h17;
    localparam logic [6:0] OP_SYSTEM = 7'h73;

    // Branch conditions
    localparam funct3_t F3_BEQ  = 3'h0;
    localparam funct3_t F3_BNE  = 3'h1;
    localparam funct3_t F3_BLT  = 3'h4;
    localparam funct3_t F3_BGE  = 3'h5;
    localparam funct3_t F3_BLTU = 3'h6;
    localparam funct3_t F3_BGEU = 3'h7;

endpackage

`default_nettype wire

//--- source/register_file.sv
// ------------------------------
// General register file, x1 to x31
// Two combinational reads, one clocked write
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

module register_file (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire cpu_pkg::reg_addr_t rs1,
    input  wire cpu_pkg::reg_addr_t rs2,
    output cpu_pkg::word_t          rs1_data,
    output cpu_pkg::word_t          rs2_data,
    input  wire logic               rd_write,
    input  wire cpu_pkg::reg_addr_t rd_addr,
    input  wire cpu_pkg::word_t     rd_data
);

    cpu_pkg::word_t regs [1:31];    // No storage for x0

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_write && rd_addr != 5'd0) begin
            regs[rd_addr] <= rd_data;
        end
    end

    assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

//--- core/alu.sv
// ------------------------------
// Integer ALU with a separate branch comparator
// Fully combinational
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

module alu (
    input  wire cpu_pkg::alu_op_e alu_op,
    input  wire cpu_pkg::word_t   a,
    input  wire cpu_pkg::word_t   b,
    input  wire cpu_pkg::funct3_t funct3,
    output cpu_pkg::word_t        result,
    output logic                  branch_taken
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (alu_op)
            cpu_pkg::ALU_ADD:    result = a + b;
            cpu_pkg::ALU_SUB:    result = a - b;
            cpu_pkg::ALU_SLL:    result = a << shamt;
            cpu_pkg::ALU_SLT:    result = {31'b0, $signed(a) < $signed(b)};
            cpu_pkg::ALU_SLTU:   result = {31'b0, a < b};
            cpu_pkg::ALU_XOR:    result = a ^ b;
            cpu_pkg::ALU_SRL:    result = a >> shamt;
            cpu_pkg::ALU_SRA:    result = $signed(a) >>> shamt;
            cpu_pkg::ALU_OR:     result = a | b;
            cpu_pkg::ALU_AND:    result = a & b;
            cpu_pkg::ALU_PASS_B: result = b;
            default:             result = a + b;
        endcase
    end

    // Branch condition, a and b carry rs1 and rs2
    always_comb begin
        case (funct3)
            cpu_pkg::F3_BEQ:  branch_taken = (a == b);
            cpu_pkg::F3_BNE:  branch_taken = (a != b);
            cpu_pkg::F3_BLT:  branch_taken = ($signed(a) < $signed(b));
            cpu_pkg::F3_BGE:  branch_taken = ($signed(a) >= $signed(b));
            cpu_pkg::F3_BLTU: branch_taken = (a < b);
            cpu_pkg::F3_BGEU: branch_taken = (a >= b);
            default:          branch_taken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- core/load_formatter.sv
// ------------------------------
// Load data alignment and extension
// Picks the little-endian lane and extends it by funct3
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

module load_formatter (
    input  wire cpu_pkg::word_t   load_word,
    input  wire logic [1:0]       byte_offset,
    input  wire cpu_pkg::funct3_t funct3,
    output cpu_pkg::word_t        load_value
);

    logic [7:0]  byte_val;
    logic [15:0] half_val;

    always_comb begin
        case (byte_offset)
            2'd0:    byte_val = load_word[7:0];
            2'd1:    byte_val = load_word[15:8];
            2'd2:    byte_val = load_word[23:16];
            default: byte_val = load_word[31:24];
        endcase
    end

    assign half_val = byte_offset[1] ? load_word[31:16] : load_word[15:0];

    always_comb begin
        case (funct3)
            3'b000:  load_value = {{24{byte_val[7]}}, byte_val};    // LB
            3'b001:  load_value = {{16{half_val[15]}}, half_val};   // LH
            3'b100:  load_value = {24'b0, byte_val};                // LBU
            3'b101:  load_value = {16'b0, half_val};                // LHU
            default: load_value = load_word;                        // LW
        endcase
    end

endmodule

`default_nettype wire

//--- core/instr_decoder.sv
// ------------------------------
// RV32I instruction decoder
// Builds the control struct and the sign-extended immediate
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

module instr_decoder (
    input  wire cpu_pkg::word_t instr,
    output cpu_pkg::ctrl_t      ctrl,
    output cpu_pkg::word_t      imm
);

    logic [6:0]     opcode;
    logic           alt;           // funct7 bit 5, imm[10] for shifts
    cpu_pkg::word_t imm_i;
    cpu_pkg::word_t imm_s;
    cpu_pkg::word_t imm_b;
    cpu_pkg::word_t imm_u;
    cpu_pkg::word_t imm_j;

    assign opcode = instr[6:0];
    assign alt    = instr[30];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // ALU operation of the OP and OP-IMM groups
    function automatic cpu_pkg::alu_op_e arith_op(input cpu_pkg::funct3_t f3,
                                                  input logic is_reg, input logic alt_bit);
        case (f3)
            3'b000:  arith_op = (is_reg && alt_bit) ? cpu_pkg::ALU_SUB : cpu_pkg::ALU_ADD;
            3'b001:  arith_op = cpu_pkg::ALU_SLL;
            3'b010:  arith_op = cpu_pkg::ALU_SLT;
            3'b011:  arith_op = cpu_pkg::ALU_SLTU;
            3'b100:  arith_op = cpu_pkg::ALU_XOR;
            3'b101:  arith_op = alt_bit ? cpu_pkg::ALU_SRA : cpu_pkg::ALU_SRL;
            3'b110:  arith_op = cpu_pkg::ALU_OR;
            default: arith_op = cpu_pkg::ALU_AND;
        endcase
    endfunction

    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = cpu_pkg::ALU_ADD;
        ctrl.funct3 = instr[14:12];
        ctrl.rd     = instr[11:7];
        ctrl.rs1    = instr[19:15];
        ctrl.rs2    = instr[24:20];
        imm         = imm_i;

        case (opcode)
            cpu_pkg::OP_LOAD: begin
                ctrl.is_load   = 1'b1;
                ctrl.use_imm_b = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            cpu_pkg::OP_STORE: begin
                ctrl.is_store  = 1'b1;
                ctrl.use_imm_b = 1'b1;
                imm            = imm_s;
            end
            cpu_pkg::OP_BRANCH: begin   // ALU compares rs1 with rs2
                ctrl.is_branch = 1'b1;
                imm            = imm_b;
            end
            cpu_pkg::OP_JAL: begin
                ctrl.is_jal    = 1'b1;
                ctrl.reg_write = 1'b1;
                imm            = imm_j;
            end
            cpu_pkg::OP_JALR: begin
                ctrl.is_jalr   = 1'b1;
                ctrl.use_imm_b = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            cpu_pkg::OP_IMM: begin
                ctrl.alu_op    = arith_op(ctrl.funct3, 1'b0, alt);
                ctrl.use_imm_b = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            cpu_pkg::OP_REG: begin
                ctrl.alu_op    = arith_op(ctrl.funct3, 1'b1, alt);
                ctrl.reg_write = 1'b1;
            end
            cpu_pkg::OP_LUI: begin
                ctrl.alu_op    = cpu_pkg::ALU_PASS_B;
                ctrl.use_imm_b = 1'b1;
                ctrl.reg_write = 1'b1;
                imm            = imm_u;
            end
            cpu_pkg::OP_AUIPC: begin
                ctrl.use_pc_a  = 1'b1;
                ctrl.use_imm_b = 1'b1;
                ctrl.reg_write = 1'b1;
                imm            = imm_u;
            end
            cpu_pkg::OP_SYSTEM: begin
                ctrl.is_ebreak = (instr[31:20] == 12'h001) && (ctrl.funct3 == 3'b000);
            end
            default: ;                  // Unknown opcode does nothing
        endcase
    end

endmodule

`default_nettype wire

//--- core/cpu_sequencer.sv
// ------------------------------
// Instruction sequencer of the multicycle core
// Runs fetch, decode, execute, memory and writeback, owns the PC and the bus
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

module cpu_sequencer #(
    parameter cpu_pkg::word_t RESET_PC = 32'h8000
) (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 mem_ready,
    input  wire cpu_pkg::word_t       mem_rdata,
    output cpu_pkg::mem_req_t         mem_req,
    output cpu_pkg::word_t            instr,
    input  wire cpu_pkg::ctrl_t       ctrl,
    input  wire cpu_pkg::word_t       imm,
    input  wire cpu_pkg::word_t       rs1_data,
    input  wire cpu_pkg::word_t       rs2_data,
    output cpu_pkg::word_t            alu_a,
    output cpu_pkg::word_t            alu_b,
    input  wire cpu_pkg::word_t       alu_result,
    input  wire logic                 branch_taken,
    output cpu_pkg::word_t            load_word,
    input  wire cpu_pkg::word_t       load_value,
    output logic                      rd_write,
    output cpu_pkg::reg_addr_t        rd_addr,
    output cpu_pkg::word_t            rd_data,
    output logic                      halted
);

    localparam cpu_pkg::funct3_t SIZE_WORD = 3'b010;

    typedef enum logic [2:0] {
        S_FETCH,
        S_DECODE,
        S_EXECUTE,
        S_MEMORY,
        S_WRITEBACK
    } state_e;

    state_e         state_q, state_d;
    cpu_pkg::word_t pc_q;
    cpu_pkg::word_t instr_q;
    cpu_pkg::word_t alu_result_q;
    cpu_pkg::word_t load_word_q;
    logic           halted_q;
    logic           advance;       // Step taken at this edge
    cpu_pkg::word_t pc_plus4;
    cpu_pkg::word_t pc_target;
    cpu_pkg::word_t next_pc;

    assign advance   = mem_ready && !halted_q;
    assign pc_plus4  = pc_q + 32'd4;
    assign pc_target = pc_q + imm;    // JAL and branch target

    always_comb begin
        case (state_q)
            S_FETCH:     state_d = S_DECODE;
            S_DECODE:    state_d = S_EXECUTE;
            S_EXECUTE:   state_d = (ctrl.is_load || ctrl.is_store) ? S_MEMORY : S_WRITEBACK;
            S_MEMORY:    state_d = S_WRITEBACK;
            default:     state_d = S_FETCH;
        endcase
    end

    always_comb begin
        if (ctrl.is_jalr) begin
            next_pc = {alu_result_q[31:1], 1'b0};
        end else if (ctrl.is_jal || (ctrl.is_branch && branch_taken)) begin
            next_pc = pc_target;
        end else begin
            next_pc = pc_plus4;
        end
    end

    // ------------------------------
    // Control state
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q  <= S_FETCH;
            pc_q     <= RESET_PC;
            instr_q  <= '0;          // Decodes to no operation
            halted_q <= 1'b0;
        end else if (advance) begin
            state_q <= state_d;
            case (state_q)
                S_FETCH:     instr_q <= mem_rdata;
                S_EXECUTE:   halted_q <= ctrl.is_ebreak;
                S_WRITEBACK: pc_q <= next_pc;
                default:     ;
            endcase
        end
    end

    // Result and load data
    always_ff @(posedge clk) begin
        if (advance) begin
            if (state_q == S_EXECUTE) begin
                alu_result_q <= alu_result;
            end
            if (state_q == S_MEMORY && ctrl.is_load) begin
                load_word_q <= mem_rdata;
            end
        end
    end

    // ------------------------------
    // Bus request and datapath
    // ------------------------------
    always_comb begin
        mem_req.addr  = (state_q == S_MEMORY || state_q == S_WRITEBACK) ? alu_result_q : pc_q;
        mem_req.wdata = rs2_data;
        mem_req.read  = (state_q == S_FETCH) || (state_q == S_MEMORY && ctrl.is_load);
        mem_req.write = (state_q == S_MEMORY) && ctrl.is_store;
        mem_req.size  = (state_q == S_FETCH) ? SIZE_WORD : ctrl.funct3;
    end

    assign alu_a = ctrl.use_pc_a ? pc_q : rs1_data;
    assign alu_b = ctrl.use_imm_b ? imm : rs2_data;

    assign instr     = instr_q;
    assign load_word = load_word_q;
    assign halted    = halted_q;

    // Register write once, at the edge that leaves writeback
    assign rd_write = (state_q == S_WRITEBACK) && ctrl.reg_write && advance;
    assign rd_addr  = ctrl.rd;
    assign rd_data  = ctrl.is_load                  ? load_value :
                      (ctrl.is_jal || ctrl.is_jalr) ? pc_plus4   :  // Link address
                                                      alu_result_q;

endmodule

`default_nettype wire

//--- core/cpu_core.sv
// ------------------------------
// Multicycle RV32I core, top level
// One bus for fetch and data, halts on EBREAK
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

module cpu_core #(
    parameter cpu_pkg::word_t RESET_PC = 32'h8000
) (
    input  wire logic             clk,
    input  wire logic             rst_n,
    output cpu_pkg::mem_req_t     mem_req,
    input  wire cpu_pkg::word_t   mem_rdata,
    input  wire logic             mem_ready,
    output logic                  halted
);

    cpu_pkg::word_t     instr;
    cpu_pkg::ctrl_t     ctrl;
    cpu_pkg::word_t     imm;
    cpu_pkg::word_t     rs1_data;
    cpu_pkg::word_t     rs2_data;
    cpu_pkg::word_t     alu_a;
    cpu_pkg::word_t     alu_b;
    cpu_pkg::word_t     alu_result;
    logic               branch_taken;
    cpu_pkg::word_t     load_word;
    cpu_pkg::word_t     load_value;
    logic               rd_write;
    cpu_pkg::reg_addr_t rd_addr;
    cpu_pkg::word_t     rd_data;

    cpu_sequencer #(
        .RESET_PC (RESET_PC)
    ) sequencer_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .mem_ready    (mem_ready),
        .mem_rdata    (mem_rdata),
        .mem_req      (mem_req),
        .instr        (instr),
        .ctrl         (ctrl),
        .imm          (imm),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .alu_a        (alu_a),
        .alu_b        (alu_b),
        .alu_result   (alu_result),
        .branch_taken (branch_taken),
        .load_word    (load_word),
        .load_value   (load_value),
        .rd_write     (rd_write),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data),
        .halted       (halted)
    );

    instr_decoder decoder_i (
        .instr (instr),
        .ctrl  (ctrl),
        .imm   (imm)
    );

    alu alu_i (
        .alu_op       (ctrl.alu_op),
        .a            (alu_a),
        .b            (alu_b),
        .funct3       (ctrl.funct3),
        .result       (alu_result),
        .branch_taken (branch_taken)
    );

    // Request address holds the data address from memory step through writeback
    load_formatter load_formatter_i (
        .load_word   (load_word),
        .byte_offset (mem_req.addr[1:0]),
        .funct3      (ctrl.funct3),
        .load_value  (load_value)
    );

    register_file register_file_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1      (ctrl.rs1),
        .rs2      (ctrl.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .rd_write (rd_write),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data)
    );

endmodule

`default_nettype wire

//--- bench/tb_cpu_core.sv
// ------------------------------
// Testbench of the multicycle RV32I core
// Runs the program from the trace file on a stalling memory model
// and checks every store and the final halt
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

module tb_cpu_core;

    localparam int CLK_PERIOD = 8;
    localparam int QUIET_CYCLES = 20;    // Bus must stay idle this long after halt

    typedef struct packed {
        cpu_pkg::word_t   addr;
        cpu_pkg::word_t   data;
        cpu_pkg::funct3_t size;
    } store_t;

    logic              clk = 1'b0;
    logic              rst_n;
    cpu_pkg::mem_req_t mem_req;
    cpu_pkg::word_t    mem_rdata;
    logic              mem_ready;
    logic              halted;

    cpu_pkg::word_t mem [cpu_pkg::word_t];    // Sparse map keyed by word address
    store_t         expected_stores [$];
    int             expected_count;
    int             stores_seen;
    logic           trace_loaded;
    int             seed;

    cpu_core #(
        .RESET_PC (32'h8000)
    ) cpu_core_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_req   (mem_req),
        .mem_rdata (mem_rdata),
        .mem_ready (mem_ready),
        .halted    (halted)
    );

    initial begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ------------------------------
    // Helpers
    // ------------------------------
    task automatic check_value(input string what, input cpu_pkg::word_t got,
                               input cpu_pkg::word_t exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1);
    endtask

    function automatic cpu_pkg::word_t read_word(input cpu_pkg::word_t addr);
        if (mem.exists(addr[31:2])) begin
            return mem[addr[31:2]];
        end
        return '0;
    endfunction

    // Store data comes in the low lanes and the address picks the lane
    task automatic write_memory(input cpu_pkg::word_t addr, input cpu_pkg::word_t data,
                                input cpu_pkg::funct3_t size);
        cpu_pkg::word_t w;
        w = read_word(addr);
        case (size[1:0])
            2'b00:   w[addr[1:0]*8 +: 8] = data[7:0];
            2'b01:   w[addr[1]*16 +: 16] = data[15:0];
            default: w = data;
        endcase
        mem[addr[31:2]] = w;
    endtask

    task automatic load_trace();
        int             fd;
        int             r;
        string          tag;
        string          rest;
        cpu_pkg::word_t a;
        cpu_pkg::word_t d;
        cpu_pkg::word_t s;
        store_t         st;
        fd = $fopen("bench/cpu_trace.txt", "r");
        if (fd == 0) begin
            stop_with_error("Cannot open the trace file bench/cpu_trace.txt");
        end
        expected_count = -1;
        while (!$feof(fd)) begin
            r = $fscanf(fd, "%s", tag);
            if (r != 1) begin
                break;
            end
            if (tag == "#") begin
                r = $fgets(rest, fd);    // Comment line
            end else if (tag == "P") begin
                r = $fscanf(fd, "%h %h", a, d);
                mem[a[31:2]] = d;
            end else if (tag == "S") begin
                r = $fscanf(fd, "%h %h %h", a, d, s);
                st.addr = a;
                st.data = d;
                st.size = s[2:0];
                expected_stores.push_back(st);
            end else if (tag == "E") begin
                r = $fscanf(fd, "%d", expected_count);
            end else begin
                stop_with_error("The trace file holds a line of unknown kind");
            end
        end
        $fclose(fd);
        if (expected_count != expected_stores.size()) begin
            stop_with_error("The end line of the trace does not match its store lines");
        end
    endtask

    // ------------------------------
    // Memory model
    // ------------------------------
    always @(negedge clk) begin
        mem_ready <= (($random(seed) & 3) != 0);    // Stall one edge in four
        if (mem_req.read) begin
            mem_rdata <= read_word(mem_req.addr);
        end else begin
            mem_rdata <= '0;
        end
    end

    // Stores happen and are checked at the edge with mem_ready high
    always @(posedge clk) begin
        if (rst_n && mem_req.write && mem_ready) begin
            if (stores_seen >= expected_count) begin
                stop_with_error("The core made a store beyond the expected ones");
            end
            check_value("store address", mem_req.addr, expected_stores[stores_seen].addr);
            check_value("store data", mem_req.wdata, expected_stores[stores_seen].data);
            check_value("store size", {29'b0, mem_req.size},
                        {29'b0, expected_stores[stores_seen].size});
            write_memory(mem_req.addr, mem_req.wdata, mem_req.size);
            stores_seen = stores_seen + 1;
        end
    end

    // Watchdog
    initial begin
        wait (trace_loaded);
        repeat (40 * expected_count + 400) @(posedge clk);
        $display("Timeout, the core did not halt in time");
        $display("Verification failed");
        $fatal(1);
    end

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        rst_n        = 1'b0;
        mem_ready    = 1'b0;
        mem_rdata    = '0;
        stores_seen  = 0;
        trace_loaded = 1'b0;
        seed         = 32'he0541674;

        load_trace();
        trace_loaded = 1'b1;

        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        check_value("halted after reset", {31'b0, halted}, 32'd0);
        check_value("read in the first cycle", {31'b0, mem_req.read}, 32'd1);
        check_value("first fetch address", mem_req.addr, 32'h8000);

        while (!halted) begin
            @(negedge clk);
        end
        check_value("stores before halt", stores_seen, expected_count);

        for (int i = 0; i < QUIET_CYCLES; i++) begin
            @(negedge clk);
            check_value("read after halt", {31'b0, mem_req.read}, 32'd0);
            check_value("write after halt", {31'b0, mem_req.write}, 32'd0);
        end

        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/cpu_trace.txt
# P address instruction, S address data size, E number of stores
# All values hex except the store count
P 00008000 000090B7
P 00008004 FFD00113
P 00008008 00500193
P 0000800C 40218233
P 00008010 0040A023
P 00008014 40115293
P 00008018 0032C333
P 0000801C 0060A223
P 00008020 0021B3B3
P 00008024 00708423
P 00008028 00001417
P 0000802C 0080A623
P 00008030 10008483
P 00008034 0090A823
P 00008038 10108483
P 0000803C 0090A823
P 00008040 10208483
P 00008044 0090A823
P 00008048 10308483
P 0000804C 0090A823
P 00008050 1000C483
P 00008054 0090A823
P 00008058 1030C483
P 0000805C 0090A823
P 00008060 10009483
P 00008064 0090A823
P 00008068 10209483
P 0000806C 0090A823
P 00008070 1020D483
P 00008074 0090A823
# Branches, not taken then taken, each pair guarding a stray store
P 00008078 00310463
P 0000807C 00318463
P 00008080 0000AA23
P 00008084 00319463
P 00008088 00311463
P 0000808C 0000AA23
P 00008090 0021C463
P 00008094 00314463
P 00008098 0000AA23
P 0000809C 00315463
P 000080A0 0021D463
P 000080A4 0000AA23
P 000080A8 00316463
P 000080AC 0021E463
P 000080B0 0000AA23
P 000080B4 0021F463
P 000080B8 00317463
P 000080BC 0000AA23
# JAL, JALR with odd offset, EBREAK
P 000080C0 0080056F
P 000080C4 0000AA23
P 000080C8 00A0AC23
P 000080CC 01150667
P 000080D0 0000AA23
P 000080D4 00C0AE23
P 000080D8 00100073
P 000080DC 0000AA23
# Load source word
P 00009100 807F01FE
S 00009000 00000008 2
S 00009004 FFFFFFFB 2
S 00009008 00000001 0
S 0000900C 00009028 2
S 00009010 FFFFFFFE 2
S 00009010 00000001 2
S 00009010 0000007F 2
S 00009010 FFFFFF80 2
S 00009010 000000FE 2
S 00009010 00000080 2
S 00009010 000001FE 2
S 00009010 FFFF807F 2
S 00009010 0000807F 2
S 00009018 000080C4 2
S 0000901C 000080D0 2
E 15

//--- sources.f
common/cpu_pkg.sv
source/register_file.sv
core/alu.sv
core/load_formatter.sv
core/instr_decoder.sv
core/cpu_sequencer.sv
core/cpu_core.sv
bench/tb_cpu_core.sv

//--- Bender.yml
package:
  name: cpu_core

sources:
  - common/cpu_pkg.sv
  - source/register_file.sv
  - core/alu.sv
  - core/load_formatter.sv
  - core/instr_decoder.sv
  - core/cpu_sequencer.sv
  - core/cpu_core.sv
  - target: test
    files:
      - bench/tb_cpu_core.sv
